/* vlog.f */
hdl/gf_pkg.sv
hdl/gf_op_if.sv
hdl/gf_step_counter.sv
hdl/gf_axil_regs.sv
hdl/gf_op_fsm.sv
hdl/gf_datapath.sv
hdl/gf_alu_top.sv
dv/tb_gf_alu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_gf_alu
FILELIST = vlog.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_gf_alu.sv */
module tb_gf_alu;
	timeunit 1ns;
	timeprecision 1ps;
	import gf_pkg::*;

	localparam int clk_period = 8;
	localparam int watchdog_ns = (200 * 20 + 16) * clk_period; // 200 transactions, 20 cycles each.

	logic clk;
	logic rst_n;
	logic [axil_addr_w-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axil_data_w-1:0] wdata;
	logic [axil_data_w/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	axi_resp_e bresp;
	logic bvalid;
	logic bready;
	logic [axil_addr_w-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axil_data_w-1:0] rdata;
	axi_resp_e rresp;
	logic rvalid;
	logic rready;
	int seed;

	gf_alu_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_elem(input string what, input gf_elem_t got, input gf_elem_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH %0t %s: got %0h, expected %0h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_resp(input string what, input axi_resp_e got, input axi_resp_e exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH %0t %s: got %s, expected %s",
				$time, what, got.name(), exp.name()));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH %0t %s: got %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Called 1 ns after a rising edge, returns at the same phase.
	task automatic axil_write(input logic [axil_addr_w-1:0] addr,
		input logic [axil_data_w-1:0] data, output axi_resp_e resp);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) begin
			@(negedge clk);                           // Ready seen mid cycle.
		end
		@(posedge clk);                               // Address and data handshake.
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);                               // Response accepted here.
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [axil_addr_w-1:0] addr,
		output logic [axil_data_w-1:0] data, output axi_resp_e resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic write_ok(input logic [axil_addr_w-1:0] addr,
		input logic [axil_data_w-1:0] data);
		axi_resp_e resp;
		axil_write(addr, data, resp);
		check_resp($sformatf("write response at %0h", addr), resp, resp_okay);
	endtask

	task automatic read_ok(input logic [axil_addr_w-1:0] addr,
		output logic [axil_data_w-1:0] data);
		axi_resp_e resp;
		axil_read(addr, data, resp);
		check_resp($sformatf("read response at %0h", addr), resp, resp_okay);
	endtask

	// Poll STATUS until busy drops.
	task automatic wait_idle(output logic [axil_data_w-1:0] status);
		int polls;
		polls = 0;
		do begin
			read_ok(addr_status, status);
			polls++;
			if (polls > 50) begin
				stop_with_failure("The core stayed busy long after the operation started.");
			end
		end while (status[0]);
	endtask

	task automatic run_op(input gf_op_e op, input gf_elem_t a, input gf_elem_t b,
		output gf_elem_t res, output logic dz);
		logic [axil_data_w-1:0] word;
		write_ok(addr_opa, axil_data_w'(a));
		write_ok(addr_opb, axil_data_w'(b));
		write_ok(addr_ctrl, axil_data_w'(op));          // Starts the core.
		wait_idle(word);
		dz = word[1];
		read_ok(addr_result, word);
		res = word[gf_m-1:0];
	endtask

	// Reference field model, shift and reduce.
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t x;
		gf_elem_t p;
		x = a;
		p = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i]) begin
				p = p ^ x;
			end
			x = x[gf_m-1] ? ((x << 1) ^ gf_poly) : (x << 1); // Times alpha.
		end
		return p;
	endfunction

	function automatic gf_elem_t gf_cube(gf_elem_t a);
		return gf_mul(gf_mul(a, a), a);
	endfunction

	function automatic gf_elem_t gf_inv(gf_elem_t b);
		for (int i = 1; i < (1 << gf_m); i++) begin
			if (gf_mul(b, gf_elem_t'(i)) == gf_elem_t'(1)) begin
				return gf_elem_t'(i);
			end
		end
		return '0;                                      // Zero has no inverse.
	endfunction

	function automatic gf_elem_t rand_nonzero();
		gf_elem_t v;
		v = '0;
		while (v == '0) begin
			v = gf_elem_t'($random(seed));
		end
		return v;
	endfunction

	task automatic register_access();
		logic [axil_data_w-1:0] word;
		axi_resp_e resp;
		check_flag("ready and valid low after reset",
			awready | wready | bvalid | arready | rvalid, 1'b0);
		read_ok(addr_result, word);
		check_elem("RESULT after reset", word[gf_m-1:0], '0);
		read_ok(addr_status, word);
		check_flag("busy after reset", word[0], 1'b0);
		check_flag("div_zero after reset", word[1], 1'b0);
		write_ok(addr_opa, 32'h55);
		write_ok(addr_opb, 32'h2A);
		read_ok(addr_opa, word);
		check_elem("OPA readback", word[gf_m-1:0], 7'h55);
		read_ok(addr_opb, word);
		check_elem("OPB readback", word[gf_m-1:0], 7'h2A);
		axil_read(5'h14, word, resp);                   // Past the last register.
		check_resp("unmapped read", resp, resp_slverr);
		check_flag("unmapped read data is zero", word == '0, 1'b1);
		axil_write(5'h1C, 32'h1, resp);
		check_resp("unmapped write", resp, resp_slverr);
	endtask

	task automatic multiply_products();
		gf_elem_t edges [3];
		gf_elem_t a;
		gf_elem_t b;
		gf_elem_t res;
		logic dz;
		edges = '{7'h00, 7'h01, 7'h40};                 // Zero, one, alpha^6.
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				run_op(op_mul, edges[i], edges[j], res, dz);
				check_elem("edge product", res, gf_mul(edges[i], edges[j]));
			end
		end
		for (int n = 0; n < 30; n++) begin
			a = gf_elem_t'($random(seed));
			b = gf_elem_t'($random(seed));
			run_op(op_mul, a, b, res, dz);
			check_elem($sformatf("product %0h*%0h", a, b), res, gf_mul(a, b));
		end
		a = rand_nonzero();
		b = rand_nonzero();
		run_op(gf_op_e'(2'd3), a, b, res, dz);          // Reserved code runs as multiply.
		check_elem($sformatf("reserved code product %0h*%0h", a, b), res, gf_mul(a, b));
	endtask

	task automatic cube_results();
		gf_elem_t a;
		gf_elem_t res;
		logic dz;
		for (int n = 0; n < 30; n++) begin
			a = gf_elem_t'($random(seed));
			run_op(op_cube, a, gf_elem_t'($random(seed)), res, dz); // B is a don't care.
			check_elem($sformatf("cube of %0h", a), res, gf_cube(a));
		end
	endtask

	task automatic divide_quotients();
		gf_elem_t a;
		gf_elem_t b;
		gf_elem_t res;
		logic dz;
		for (int n = 0; n < 30; n++) begin
			a = gf_elem_t'($random(seed));
			b = rand_nonzero();
			run_op(op_div, a, b, res, dz);
			check_elem($sformatf("quotient %0h/%0h", a, b), res, gf_mul(a, gf_inv(b)));
			check_flag("div_zero on valid divide", dz, 1'b0);
		end
	endtask

	task automatic divide_by_zero();
		gf_elem_t a;
		gf_elem_t res;
		logic dz;
		a = rand_nonzero();
		run_op(op_mul, a, a, res, dz);                  // Leaves a nonzero result.
		check_elem("square before divide by zero", res, gf_mul(a, a));
		run_op(op_div, a, '0, res, dz);
		check_elem("quotient by zero", res, '0);
		check_flag("div_zero after divide by zero", dz, 1'b1);
		run_op(op_mul, a, a, res, dz);                  // Next start clears the flag.
		check_elem("square after divide by zero", res, gf_mul(a, a));
		check_flag("div_zero after next start", dz, 1'b0);
	endtask

	task automatic busy_protection();
		logic [axil_data_w-1:0] word;
		gf_elem_t a;
		gf_elem_t b;
		a = rand_nonzero();
		b = rand_nonzero();
		write_ok(addr_opa, axil_data_w'(a));
		write_ok(addr_opb, axil_data_w'(b));
		write_ok(addr_ctrl, axil_data_w'(op_div));
		write_ok(addr_ctrl, axil_data_w'(op_mul));      // Lands inside the divide loop.
		read_ok(addr_status, word);
		check_flag("busy during divide", word[0], 1'b1);
		wait_idle(word);
		read_ok(addr_result, word);
		check_elem("result after ignored start", word[gf_m-1:0], gf_mul(a, gf_inv(b)));
	endtask

	initial begin
		#(watchdog_ns);
		stop_with_failure("Watchdog timeout, the tests did not finish in time.");
	end

	initial begin
		seed = 17595;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		register_access();
		multiply_products();
		cube_results();
		divide_quotients();
		divide_by_zero();
		busy_protection();
		$display("test passed");
		$finish;
	end

endmodule

/* hdl/gf_alu_top.sv */
module gf_alu_top (
	input logic clk,
	input logic rst_n,
	input logic [gf_pkg::axil_addr_w-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [gf_pkg::axil_data_w-1:0] wdata,
	input logic [gf_pkg::axil_data_w/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output gf_pkg::axi_resp_e bresp,
	output logic bvalid,
	input logic bready,
	input logic [gf_pkg::axil_addr_w-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [gf_pkg::axil_data_w-1:0] rdata,
	output gf_pkg::axi_resp_e rresp,
	output logic rvalid,
	input logic rready
);

	gf_op_if i_op_if ();            // Registers to core.
	gf_step_if i_step_if ();        // FSM to datapath.

	gf_axil_regs i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.op(i_op_if.regs)
	);

	gf_op_fsm i_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.op(i_op_if.core),
		.step(i_step_if.fsm)
	);

	gf_datapath i_dp (
		.clk(clk),
		.rst_n(rst_n),
		.op(i_op_if.core),          // Drives result only.
		.step(i_step_if.dp)
	);

endmodule

/* hdl/gf_datapath.sv */
module gf_datapath (
	input logic clk,
	input logic rst_n,
	gf_op_if.core op,
	gf_step_if.dp step
);
	import gf_pkg::*;

	gf_elem_t a_q;
	gf_elem_t b_q;
	gf_elem_t sq;
	gf_elem_t acc;
	gf_elem_t result_q;
	gf_elem_t sq_src;
	gf_elem_t sq_next;
	gf_elem_t mul_x;
	gf_elem_t mul_y;
	gf_elem_t shifted;
	gf_elem_t prod;

	// Squarer from the even powers of alpha.
	always_comb begin
		if (step.load) begin
			sq_src = (step.sel == op_cube) ? a_q : b_q;         // Cube squares A.
		end else begin
			sq_src = sq;
		end
		sq_next = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (sq_src[i]) begin
				sq_next = sq_next ^ gf_alpha_pow(2 * i);
			end
		end
	end

	// Operand select for the single multiplier.
	always_comb begin
		if (step.finish) begin
			mul_y = a_q;
			case (step.sel)
				op_div: mul_x = acc;                           // A * B^-1.
				op_cube: mul_x = sq;                           // A * A^2.
				default: mul_x = b_q;
			endcase
		end else begin
			mul_x = acc;
			mul_y = sq;
		end
	end

	// Parallel multiplier. Sum of shifted, reduced copies.
	always_comb begin
		shifted = mul_x;
		prod = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (mul_y[i]) begin
				prod = prod ^ shifted;
			end
			shifted = gf_xtime(shifted);
		end
	end

	always_ff @(posedge clk) begin
		if (op.start) begin
			a_q <= op.opa;                                     // Private operand copies.
			b_q <= op.opb;
		end
	end

	always_ff @(posedge clk) begin
		if (step.load) begin
			sq <= sq_next;
			acc <= gf_elem_t'(1);                              // Empty product.
		end else if (step.iterate) begin
			sq <= sq_next;
			acc <= prod;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_q <= '0;
		end else if (step.finish) begin
			result_q <= prod;
		end
	end

	assign op.result = result_q;
	assign step.is_zero_b = (b_q == '0);

endmodule

/* hdl/gf_op_fsm.sv */
module gf_op_fsm (
	input logic clk,
	input logic rst_n,
	gf_op_if.core op,
	gf_step_if.fsm step
);
	import gf_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_square_loop,
		st_final,
		st_done
	} state_e;

	state_e state;
	state_e state_next;
	gf_op_e op_q;
	gf_op_e op_norm;
	gf_op_e sel;
	logic div_zero_q;
	logic abort;
	logic load;
	logic iterate;
	logic finish;
	logic cnt_clear;
	logic cnt_advance;
	logic cnt_last;

	gf_step_counter i_step_cnt (
		.clk(clk),
		.rst_n(rst_n),
		.clear(cnt_clear),
		.advance(cnt_advance),
		.last(cnt_last)
	);

	// Reserved code runs as multiply.
	assign op_norm = (op.op == op_cube || op.op == op_div) ? op.op : op_mul;

	always_comb begin
		state_next = state;
		load = 1'b0;
		iterate = 1'b0;
		finish = 1'b0;
		sel = op_q;
		abort = 1'b0;
		cnt_clear = 1'b0;
		cnt_advance = 1'b0;
		case (state)
			st_idle, st_done: begin
				if (op.start) begin
					state_next = (op_norm == op_mul) ? st_final : st_load; // Multiply skips loop.
				end
			end
			st_load: begin
				if (op_q == op_div && step.is_zero_b) begin
					abort = 1'b1;
					finish = 1'b1;                             // A*0 clears result.
					sel = op_mul;
					state_next = st_done;
				end else begin
					load = 1'b1;
					cnt_clear = 1'b1;
					state_next = (op_q == op_div) ? st_square_loop : st_final;
				end
			end
			st_square_loop: begin
				iterate = 1'b1;
				cnt_advance = 1'b1;
				if (cnt_last) begin
					state_next = st_final;                     // Sixth square done.
				end
			end
			st_final: begin
				finish = 1'b1;
				state_next = st_done;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			op_q <= op_mul;
			div_zero_q <= 1'b0;
		end else begin
			state <= state_next;
			if (op.start) begin
				op_q <= op_norm;
				div_zero_q <= 1'b0;                            // Cleared by next start.
			end else if (abort) begin
				div_zero_q <= 1'b1;
			end
		end
	end

	assign op.busy = state inside {st_load, st_square_loop, st_final};
	assign op.div_zero = div_zero_q;
	assign step.load = load;
	assign step.iterate = iterate;
	assign step.finish = finish;
	assign step.sel = sel;

endmodule

/* hdl/gf_axil_regs.sv */
module gf_axil_regs (
	input logic clk,
	input logic rst_n,
	input logic [gf_pkg::axil_addr_w-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [gf_pkg::axil_data_w-1:0] wdata,
	input logic [gf_pkg::axil_data_w/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output gf_pkg::axi_resp_e bresp,
	output logic bvalid,
	input logic bready,
	input logic [gf_pkg::axil_addr_w-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [gf_pkg::axil_data_w-1:0] rdata,
	output gf_pkg::axi_resp_e rresp,
	output logic rvalid,
	input logic rready,
	gf_op_if.regs op
);
	import gf_pkg::*;

	logic wr_hs;
	logic wr_byte0;
	logic rd_hs;
	gf_elem_t opa_q;
	gf_elem_t opb_q;
	gf_op_e ctrl_q;
	logic [axil_data_w-1:0] rd_word;

	function automatic logic addr_mapped(logic [axil_addr_w-1:0] a);
		return a inside {addr_ctrl, addr_opa, addr_opb, addr_status, addr_result};
	endfunction

	assign wr_hs = awvalid && awready && wvalid && wready;   // Both channels together.
	assign wr_byte0 = wr_hs && wstrb[0];                      // All fields sit in byte 0.
	assign rd_hs = arvalid && arready;

	assign op.start = wr_byte0 && (awaddr == addr_ctrl) && !op.busy; // Dropped while busy.
	assign op.op = gf_op_e'(wdata[1:0]);                      // Live from the bus.
	assign op.opa = opa_q;
	assign op.opb = opb_q;

	// Write channel handshake and response.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid; // Single cycle pulse.
			wready <= awvalid && wvalid && !awready && !bvalid;
			if (wr_hs) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;                                // Held until accepted.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp <= addr_mapped(awaddr) ? resp_okay : resp_slverr;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_byte0 && awaddr == addr_opa) begin
			opa_q <= wdata[gf_m-1:0];                          // Core keeps its own copy.
		end
		if (wr_byte0 && awaddr == addr_opb) begin
			opb_q <= wdata[gf_m-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= op_mul;
		end else if (op.start) begin
			ctrl_q <= op.op;                                   // Only accepted codes.
		end
	end

	// Read channel.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rd_hs) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_word = '0;                                         // Unmapped reads zero.
		case (araddr)
			addr_ctrl: rd_word[1:0] = ctrl_q;
			addr_opa: rd_word[gf_m-1:0] = opa_q;
			addr_opb: rd_word[gf_m-1:0] = opb_q;
			addr_status: begin
				rd_word[0] = op.busy;
				rd_word[1] = op.div_zero;
			end
			addr_result: rd_word[gf_m-1:0] = op.result;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata <= rd_word;
			rresp <= addr_mapped(araddr) ? resp_okay : resp_slverr;
		end
	end

endmodule

/* hdl/gf_step_counter.sv */
module gf_step_counter (
	input logic clk,
	input logic rst_n,
	input logic clear,
	input logic advance,
	output logic last
);
	import gf_pkg::*;

	logic [step_cnt_w-1:0] count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= step_cnt_w'(1);
		end else if (clear) begin
			count <= step_cnt_w'(1);                           // Reseed.
		end else if (advance) begin
			count <= step_next(count);                         // Galois shift.
		end
	end

	assign last = (count == step_last);                        // Equality on a fixed state.

endmodule

/* hdl/gf_op_if.sv */
interface gf_op_if;
	import gf_pkg::*;

	logic start;            // One cycle pulse.
	gf_op_e op;
	gf_elem_t opa;
	gf_elem_t opb;
	gf_elem_t result;       // Stable while not busy.
	logic busy;
	logic div_zero;         // Sticky until next start.

	modport regs (output start, op, opa, opb, input result, busy, div_zero);
	modport core (input start, op, opa, opb, output result, busy, div_zero);
endinterface

interface gf_step_if;
	import gf_pkg::*;

	logic load;             // Seed square and accumulator.
	logic iterate;          // Square and accumulate.
	logic finish;           // Final multiply into result.
	gf_op_e sel;            // Final multiplicand choice.
	logic is_zero_b;

	modport fsm (output load, iterate, finish, sel, input is_zero_b);
	modport dp (input load, iterate, finish, sel, output is_zero_b);
endinterface

/* hdl/gf_pkg.sv */
package gf_pkg;

	localparam int gf_m = 7;                                // Field width.
	localparam logic [gf_m-1:0] gf_poly = 7'b000_0011;      // x^7 + x + 1, top bit implied.

	typedef logic [gf_m-1:0] gf_elem_t;                     // Standard basis element.

	typedef enum logic [1:0] {
		op_mul  = 2'd0,
		op_cube = 2'd1,
		op_div  = 2'd2                                      // Code 3 reserved.
	} gf_op_e;

	localparam int step_cnt_w = 3;                          // Divide loop counter width.
	localparam logic [step_cnt_w-1:0] step_poly = 3'b011;   // x^3 + x + 1.

	localparam int axil_addr_w = 5;
	localparam int axil_data_w = 32;
	localparam logic [axil_addr_w-1:0] addr_ctrl   = 5'h00;
	localparam logic [axil_addr_w-1:0] addr_opa    = 5'h04;
	localparam logic [axil_addr_w-1:0] addr_opb    = 5'h08;
	localparam logic [axil_addr_w-1:0] addr_status = 5'h0C;
	localparam logic [axil_addr_w-1:0] addr_result = 5'h10;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

	// Multiply by alpha, then reduce.
	function automatic gf_elem_t gf_xtime(gf_elem_t x);
		return {x[gf_m-2:0], 1'b0} ^ (x[gf_m-1] ? gf_poly : '0);
	endfunction

	function automatic gf_elem_t gf_alpha_pow(int n);
		gf_elem_t p;
		p = gf_elem_t'(1);
		for (int i = 0; i < n; i++) begin
			p = gf_xtime(p);                                // One more power of alpha.
		end
		return p;
	endfunction

	function automatic logic [step_cnt_w-1:0] step_next(logic [step_cnt_w-1:0] c);
		return {c[step_cnt_w-2:0], 1'b0} ^ (c[step_cnt_w-1] ? step_poly : '0);
	endfunction

	function automatic logic [step_cnt_w-1:0] step_after(int n);
		logic [step_cnt_w-1:0] c;
		c = step_cnt_w'(1);                                 // Seed.
		for (int i = 0; i < n; i++) begin
			c = step_next(c);
		end
		return c;
	endfunction

	localparam logic [step_cnt_w-1:0] step_last = step_after(gf_m - 2); // Last loop state.

endpackage
